/* all.f */
cache_pkg.sv
cache_array.sv
bank_memory.sv
cache_ctrl_fsm.sv
mem_system.sv
tb_mem_system.sv

/* bank_memory.sv */
`default_nettype none

module bank_memory
    import cache_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  addr_t m_addr,
    input  word_t m_data_in,
    input  logic  m_rd,
    input  logic  m_wr,
    output word_t m_data_out
);

    word_sel_t bank_sel;
    bank_row_t bank_row;
    word_t     bank_rd [LINE_WORDS];

    // first read stage
    logic      rd_v1;
    word_t     rd_q1;

    // word bits pick the bank, tag and index pick the row
    assign bank_sel = m_addr[WORD_LSB +: WORD_SEL_W];
    assign bank_row = m_addr[INDEX_LSB +: BANK_ROW_W];

    for (genvar b = 0; b < LINE_WORDS; b++) begin : g_bank
        word_t mem [BANK_DEPTH] = '{default: '0};

        always_ff @(posedge clk) begin
            if (m_wr && (bank_sel == word_sel_t'(b))) begin
                mem[bank_row] <= m_data_in;
            end
        end

        assign bank_rd[b] = mem[bank_row];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_v1 <= 1'b0;
        end else begin
            rd_v1 <= m_rd;
        end
    end

    // two register stages, so a read issued in cycle n returns in n+2
    always_ff @(posedge clk) begin
        if (m_rd) begin
            rd_q1 <= bank_rd[bank_sel];
        end
        if (rd_v1) begin
            m_data_out <= rd_q1;
        end
    end

endmodule

`default_nettype wire

/* cache_array.sv */
`default_nettype none

module cache_array
    import cache_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  index_t    c_index,
    input  word_sel_t c_word,
    input  tag_t      c_tag,
    input  word_t     c_data_in,
    input  logic      c_wr,
    input  logic      c_comp,
    output logic      c_hit,
    output logic      c_valid,
    output logic      c_dirty,
    output tag_t      c_tag_out,
    output word_t     c_data_out
);

    // storage
    word_t                data_mem [NUM_LINES][LINE_WORDS];
    tag_t                 tag_mem  [NUM_LINES];
    logic [NUM_LINES-1:0] valid_bits;
    logic [NUM_LINES-1:0] dirty_bits;

    logic tag_match;
    logic word_we;
    logic install;

    // combinational lookup of the addressed line
    assign c_tag_out  = tag_mem[c_index];
    assign c_data_out = data_mem[c_index][c_word];
    assign c_valid    = valid_bits[c_index];
    assign c_dirty    = dirty_bits[c_index];

    assign tag_match = (tag_mem[c_index] == c_tag);
    assign c_hit     = c_valid & tag_match;

    // install mode writes unconditionally, compare mode only on a hit
    assign install = c_wr & ~c_comp;
    assign word_we = install | (c_wr & c_comp & c_hit);

    always_ff @(posedge clk) begin
        if (word_we) begin
            data_mem[c_index][c_word] <= c_data_in;
        end
        if (install) begin
            tag_mem[c_index] <= c_tag;
        end
    end

    // line status
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (install) begin
            // freshly fetched line is clean
            valid_bits[c_index] <= 1'b1;
            dirty_bits[c_index] <= 1'b0;
        end else if (word_we) begin
            dirty_bits[c_index] <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* cache_ctrl_fsm.sv */
`default_nettype none

module cache_ctrl_fsm
    import cache_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    // requester
    input  addr_t     addr,
    input  word_t     data_in,
    input  logic      rd,
    input  logic      wr,
    output word_t     data_out,
    output logic      done,
    output logic      stall,
    output logic      cache_hit,
    // cache array
    output index_t    c_index,
    output word_sel_t c_word,
    output tag_t      c_tag,
    output word_t     c_data_in,
    output logic      c_wr,
    output logic      c_comp,
    input  logic      c_hit,
    input  logic      c_valid,
    input  logic      c_dirty,
    input  tag_t      c_tag_out,
    input  word_t     c_data_out,
    // main memory
    output addr_t     m_addr,
    output word_t     m_data_in,
    output logic      m_rd,
    output logic      m_wr,
    input  word_t     m_data_out
);

    ctrl_state_t state;
    ctrl_state_t next_state;

    // request fields, the requester holds addr until done
    tag_t      req_tag;
    index_t    req_index;
    word_sel_t req_word;
    logic      req;
    logic      miss_start;

    tag_t      victim_tag;
    word_sel_t seq_word;
    tag_t      m_tag;
    word_sel_t m_word;

    // fill tracking
    logic [MEM_RD_LATENCY-1:0] rd_inflight;
    logic                      fill_ret;
    word_sel_t                 fill_cnt;

    word_t line_buf [LINE_WORDS];

    assign req_tag   = addr[TAG_LSB +: TAG_W];
    assign req_index = addr[INDEX_LSB +: INDEX_W];
    assign req_word  = addr[WORD_LSB +: WORD_SEL_W];
    assign req       = rd | wr;

    assign miss_start = (state == IDLE) & req & ~c_hit;
    assign fill_ret   = rd_inflight[MEM_RD_LATENCY-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (miss_start) begin
                    next_state = (c_valid && c_dirty) ? WB0 : FILL0;
                end
            end
            WB0:        next_state = WB1;
            WB1:        next_state = WB2;
            WB2:        next_state = WB3;
            WB3:        next_state = FILL0;
            FILL0:      next_state = FILL1;
            FILL1:      next_state = FILL2;
            FILL2:      next_state = FILL3;
            FILL3:      next_state = FILL_WAIT0;
            FILL_WAIT0: next_state = FILL_WAIT1;
            FILL_WAIT1: next_state = FINISH;
            FINISH:     next_state = IDLE;
            default:    next_state = IDLE;
        endcase
    end

    // old line's tag, needed to address the write-back
    always_ff @(posedge clk) begin
        if (miss_start) begin
            victim_tag <= c_tag_out;
        end
    end

    // one bit per cycle of read latency, the top bit marks a returning word
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_inflight <= '0;
            fill_cnt    <= '0;
        end else begin
            rd_inflight <= {rd_inflight[MEM_RD_LATENCY-2:0], m_rd};
            if (fill_ret) begin
                // four returns per fill, so this wraps back to zero
                fill_cnt <= fill_cnt + 1'b1;
            end
        end
    end

    // copy of the fetched line, the missed word is served from here
    always_ff @(posedge clk) begin
        if (fill_ret) begin
            line_buf[fill_cnt] <= m_data_out;
        end
    end

    // word walked by the write-back and fill-issue states
    always_comb begin
        case (state)
            WB1, FILL1: seq_word = 2'd1;
            WB2, FILL2: seq_word = 2'd2;
            WB3, FILL3: seq_word = 2'd3;
            default:    seq_word = 2'd0;
        endcase
    end

    assign m_addr    = {m_tag, req_index, m_word, 1'b0};
    assign m_data_in = c_data_out;

    always_comb begin
        // by default probe the requested word in compare mode
        c_index   = req_index;
        c_tag     = req_tag;
        c_word    = req_word;
        c_data_in = data_in;
        c_comp    = 1'b1;
        c_wr      = 1'b0;
        m_tag     = req_tag;
        m_word    = req_word;
        m_rd      = 1'b0;
        m_wr      = 1'b0;
        data_out  = c_data_out;
        done      = 1'b0;
        stall     = 1'b1;
        cache_hit = 1'b0;

        case (state)
            IDLE: begin
                // a write that misses is dropped by the array
                c_wr      = wr;
                done      = req & c_hit;
                cache_hit = req & c_hit;
                stall     = req & ~c_hit;
            end
            WB0, WB1, WB2, WB3: begin
                c_word = seq_word;
                m_tag  = victim_tag;
                m_word = seq_word;
                m_wr   = 1'b1;
            end
            FILL0, FILL1, FILL2, FILL3: begin
                m_word = seq_word;
                m_rd   = 1'b1;
            end
            FINISH: begin
                c_wr     = wr;
                data_out = line_buf[req_word];
                done     = 1'b1;
                stall    = 1'b0;
            end
            default: begin
            end
        endcase

        // returning fill data goes straight into the line
        if (fill_ret) begin
            c_word    = fill_cnt;
            c_data_in = m_data_out;
            c_comp    = 1'b0;
            c_wr      = 1'b1;
        end
    end

endmodule

`default_nettype wire

/* cache_pkg.sv */
`default_nettype none

package cache_pkg;

    // basic widths
    localparam int WORD_W     = 16;
    localparam int ADDR_W     = 16;
    localparam int TAG_W      = 5;
    localparam int INDEX_W    = 8;
    localparam int WORD_SEL_W = 2;

    // address field positions, bit 0 is the byte bit and is ignored
    localparam int WORD_LSB  = 1;
    localparam int INDEX_LSB = WORD_LSB + WORD_SEL_W;
    localparam int TAG_LSB   = INDEX_LSB + INDEX_W;

    // cache geometry
    localparam int LINE_WORDS = 4;
    localparam int NUM_LINES  = 256;

    // main memory, one bank per word of a line
    localparam int BANK_ROW_W     = TAG_W + INDEX_W;
    localparam int BANK_DEPTH     = 1 << BANK_ROW_W;
    localparam int MEM_RD_LATENCY = 2;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [ADDR_W-1:0]     addr_t;
    typedef logic [TAG_W-1:0]      tag_t;
    typedef logic [INDEX_W-1:0]    index_t;
    typedef logic [WORD_SEL_W-1:0] word_sel_t;
    typedef logic [BANK_ROW_W-1:0] bank_row_t;

    // controller states
    typedef enum logic [3:0] {
        IDLE,
        WB0,
        WB1,
        WB2,
        WB3,
        FILL0,
        FILL1,
        FILL2,
        FILL3,
        FILL_WAIT0,
        FILL_WAIT1,
        FINISH
    } ctrl_state_t;

endpackage

`default_nettype wire

/* mem_system.sv */
`default_nettype none

module mem_system
    import cache_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  addr_t addr,
    input  word_t data_in,
    input  logic  rd,
    input  logic  wr,
    output word_t data_out,
    output logic  done,
    output logic  stall,
    output logic  cache_hit
);

    // controller to cache array
    index_t    c_index;
    word_sel_t c_word;
    tag_t      c_tag;
    word_t     c_data_in;
    logic      c_wr;
    logic      c_comp;
    logic      c_hit;
    logic      c_valid;
    logic      c_dirty;
    tag_t      c_tag_out;
    word_t     c_data_out;

    // controller to main memory
    addr_t     m_addr;
    word_t     m_data_in;
    logic      m_rd;
    logic      m_wr;
    word_t     m_data_out;

    // port names match the nets above
    cache_ctrl_fsm u_ctrl (.*);

    cache_array u_cache (.*);

    bank_memory u_mem (.*);

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build with Verilator, run, then look for the fail message in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f all.f --top-module tb_mem_system -o tb_mem_system \
    > build.log 2>&1 \
    || { cat build.log; echo "verilator build failed"; exit 1; }

./obj_dir/tb_mem_system > sim.log 2>&1 \
    || echo "Regression failed" >> sim.log
cat sim.log

grep -q "Regression failed" sim.log \
    && { echo "simulation FAILED"; exit 1; } \
    || { echo "simulation PASSED"; exit 0; }

/* tb_mem_system.sv */
`default_nettype none

module tb_mem_system
    import cache_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int DONE_TIMEOUT      = 50;
    localparam int HIT_CYCLES        = 0;
    localparam int CLEAN_MISS_CYCLES = 7;
    localparam int DIRTY_MISS_CYCLES = 11;
    localparam int RANDOM_OPS        = 200;

    logic  clk;
    logic  rst_n;
    addr_t addr;
    word_t data_in;
    logic  rd;
    logic  wr;
    word_t data_out;
    logic  done;
    logic  stall;
    logic  cache_hit;

    // shadow of main memory plus a model of line state per index
    word_t shadow [addr_t];
    logic  model_valid [NUM_LINES];
    logic  model_dirty [NUM_LINES];
    tag_t  model_tag   [NUM_LINES];

    int   check_count;
    int   error_count;
    int   test_count;
    logic timed_out;

    // results of the most recent access
    word_t last_data;
    logic  last_hit;
    int    last_stall_cycles;

    mem_system uut (.*);

    always #50 clk = ~clk;

    function automatic addr_t make_addr(tag_t t, index_t i, word_sel_t w);
        return {t, i, w, 1'b0};
    endfunction

    function automatic word_t shadow_read(addr_t a);
        addr_t key;
        key = {a[15:1], 1'b0};
        if (shadow.exists(key)) begin
            return shadow[key];
        end
        return '0;
    endfunction

    task automatic check_word(string name, word_t got, word_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAILED t=%0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_cycles(string name, int got, int exp);
        check_count++;
        if (got != exp) begin
            error_count++;
            $display("FAILED t=%0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    // one request held until done and checked against the shadow and line model
    task automatic access(logic is_write, addr_t a, word_t wdata);
        index_t idx;
        tag_t   tag;
        logic   exp_hit;
        int     exp_cycles;
        int     cycles;
        logic   got_done;
        if (timed_out) begin
            return;
        end
        idx = a[10:3];
        tag = a[15:11];
        exp_hit = model_valid[idx] && (model_tag[idx] == tag);
        if (exp_hit) begin
            exp_cycles = HIT_CYCLES;
        end else if (model_dirty[idx]) begin
            exp_cycles = DIRTY_MISS_CYCLES;
        end else begin
            exp_cycles = CLEAN_MISS_CYCLES;
        end

        @(posedge clk);
        addr    <= a;
        data_in <= wdata;
        rd      <= ~is_write;
        wr      <= is_write;

        cycles   = 0;
        got_done = 1'b0;
        while (!got_done && cycles <= DONE_TIMEOUT) begin
            @(negedge clk);
            if (done) begin
                got_done  = 1'b1;
                last_data = data_out;
                last_hit  = cache_hit;
                check_bit("stall", stall, 1'b0);
            end else begin
                check_bit("stall", stall, 1'b1);
                cycles++;
            end
        end
        last_stall_cycles = cycles;

        @(posedge clk);
        rd <= 1'b0;
        wr <= 1'b0;

        if (!got_done) begin
            timed_out = 1'b1;
            error_count++;
            $display("no done within %0d cycles of the request to address %h at t=%0t",
                     DONE_TIMEOUT, a, $time);
        end else begin
            check_cycles("stall cycles", cycles, exp_cycles);
            check_bit("cache_hit", last_hit, exp_hit);
            if (is_write) begin
                shadow[{a[15:1], 1'b0}] = wdata;
            end else begin
                check_word("data_out", last_data, shadow_read(a));
            end
            if (!exp_hit) begin
                model_valid[idx] = 1'b1;
                model_tag[idx]   = tag;
                model_dirty[idx] = 1'b0;
            end
            if (is_write) begin
                model_dirty[idx] = 1'b1;
            end
            // done must drop again in the following cycle
            @(negedge clk);
            check_bit("done", done, 1'b0);
            check_bit("stall", stall, 1'b0);
        end
    endtask

    task automatic report_test(string name, int errors_before);
        test_count++;
        $display("test %0d %s finished with %0d errors", test_count, name,
                 error_count - errors_before);
    endtask

    task automatic test_idle_after_reset();
        int errors_before;
        errors_before = error_count;
        repeat (5) begin
            @(negedge clk);
            check_bit("done", done, 1'b0);
            check_bit("stall", stall, 1'b0);
        end
        report_test("idle_after_reset", errors_before);
    endtask

    task automatic test_cold_read();
        int    errors_before;
        addr_t a;
        errors_before = error_count;
        a = make_addr(5'd3, 8'h21, 2'd2);
        access(1'b0, a, '0);
        check_bit("cache_hit", last_hit, 1'b0);
        check_word("data_out", last_data, '0);
        access(1'b0, a, '0);
        check_bit("cache_hit", last_hit, 1'b1);
        check_word("data_out", last_data, '0);
        report_test("cold_read", errors_before);
    endtask

    task automatic test_line_write_read();
        int    errors_before;
        addr_t a;
        errors_before = error_count;
        for (int w = 0; w < LINE_WORDS; w++) begin
            a = make_addr(5'd7, 8'h40, word_sel_t'(w));
            access(1'b1, a, 16'ha5a0 ^ word_t'(w * 16'h0111));
            if (w > 0) begin
                check_bit("cache_hit", last_hit, 1'b1);
            end
        end
        for (int w = 0; w < LINE_WORDS; w++) begin
            a = make_addr(5'd7, 8'h40, word_sel_t'(w));
            access(1'b0, a, '0);
            check_bit("cache_hit", last_hit, 1'b1);
            check_word("data_out", last_data, 16'ha5a0 ^ word_t'(w * 16'h0111));
        end
        report_test("line_write_read", errors_before);
    endtask

    task automatic test_eviction();
        int    errors_before;
        addr_t a;
        addr_t b;
        errors_before = error_count;
        a = make_addr(5'd2, 8'h80, 2'd1);
        b = make_addr(5'd9, 8'h80, 2'd1);
        access(1'b1, b, 16'h1234);
        access(1'b1, a, 16'hbeef);
        // writing a pushed the dirty b line out to memory
        access(1'b0, b, '0);
        check_bit("cache_hit", last_hit, 1'b0);
        check_word("data_out", last_data, 16'h1234);
        access(1'b0, a, '0);
        check_bit("cache_hit", last_hit, 1'b0);
        check_word("data_out", last_data, 16'hbeef);
        report_test("eviction", errors_before);
    endtask

    task automatic test_random_traffic();
        int     errors_before;
        addr_t  pool [16];
        tag_t   tags [4];
        index_t lines [4];
        int     pick;
        errors_before = error_count;
        tags  = '{5'd1, 5'd6, 5'd11, 5'd30};
        lines = '{8'h05, 8'h06, 8'h07, 8'h08};
        for (int i = 0; i < 16; i++) begin
            pool[i] = make_addr(tags[i / 4], lines[i % 4], word_sel_t'(i / 4));
        end
        for (int n = 0; n < RANDOM_OPS; n++) begin
            pick = int'($urandom_range(15, 0));
            access(1'($urandom_range(1, 0)), pool[pick], word_t'($urandom));
        end
        report_test("random_traffic", errors_before);
    endtask

    task automatic test_stall_and_done();
        int    errors_before;
        addr_t a;
        addr_t b;
        errors_before = error_count;
        a = make_addr(5'd4, 8'hc3, 2'd3);
        b = make_addr(5'd20, 8'hc3, 2'd0);
        access(1'b1, a, 16'h0f0f);
        check_cycles("clean miss stall cycles", last_stall_cycles, CLEAN_MISS_CYCLES);
        access(1'b0, a, '0);
        check_cycles("hit stall cycles", last_stall_cycles, HIT_CYCLES);
        access(1'b0, b, '0);
        check_cycles("dirty miss stall cycles", last_stall_cycles, DIRTY_MISS_CYCLES);
        report_test("stall_and_done", errors_before);
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        addr        = '0;
        data_in     = '0;
        rd          = 1'b0;
        wr          = 1'b0;
        check_count = 0;
        error_count = 0;
        test_count  = 0;
        timed_out   = 1'b0;
        void'($urandom(32'ha977));
        for (int i = 0; i < NUM_LINES; i++) begin
            model_valid[i] = 1'b0;
            model_dirty[i] = 1'b0;
            model_tag[i]   = '0;
        end

        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        test_idle_after_reset();
        test_cold_read();
        test_line_write_read();
        test_eviction();
        test_random_traffic();
        test_stall_and_done();

        $display("%0d tests run, %0d checks, %0d errors", test_count, check_count,
                 error_count);
        if (error_count == 0 && !timed_out) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
